//--- Bender.yml
package:
  name: kbd_vga

sources:
  - kbd_pkg.sv
  - ps2_rx.sv
  - ps2_fifo.sv
  - key_decoder.sv
  - char_render.sv
  - vga_timing.sv
  - kbd_vga_top.sv
  - target: test
    files:
      - kbd_vga_tb.sv

//--- char_render.sv
module char_render #(
	parameter int unsigned GLYPH_X = 312,
	parameter int unsigned GLYPH_Y = 232
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [kbd_pkg::ADDR_W-1:0] h_addr,
	input  logic [kbd_pkg::ADDR_W-1:0] v_addr,
	input  logic                       active,
	input  logic [kbd_pkg::SC_W-1:0]   key_code,
	input  logic                       key_held,
	output logic [7:0]                 vga_r,
	output logic [7:0]                 vga_g,
	output logic [7:0]                 vga_b
);
	import kbd_pkg::*;

	localparam int unsigned ROW_W = $clog2(GLYPH_ROWS);
	localparam int unsigned COL_W = $clog2(GLYPH_COLS);

	logic [ADDR_W-1:0]     h_rel;
	logic [ADDR_W-1:0]     v_rel;
	logic                  in_box;
	logic                  known_key;
	logic [GLYPH_COLS-1:0] row_bits;
	logic                  pixel_on;
	logic                  pixel;

	// bit 0 is the leftmost column of the cell
	function automatic logic [GLYPH_COLS-1:0] glyph_row(input logic [SC_W-1:0] code,
			input logic [ROW_W-1:0] row);
		logic [GLYPH_COLS-1:0] bits;
		bits = '0;
		case (code)
			SC_Q: if (row == 4'd6 || row == 4'd9) bits = 9'h0fc;
			SC_D: begin
				case (row)
					4'd2, 4'd3, 4'd4, 4'd5: bits = 9'h0c0;
					4'd6, 4'd11: bits = 9'h0f8;
					4'd7, 4'd8, 4'd9, 4'd10: bits = 9'h0cc;
					default: bits = '0;
				endcase
			end
			default: bits = '0;
		endcase
		return bits;
	endfunction

	assign h_rel = h_addr - ADDR_W'(GLYPH_X);
	assign v_rel = v_addr - ADDR_W'(GLYPH_Y);
	assign in_box = (h_addr >= ADDR_W'(GLYPH_X)) && (h_addr < ADDR_W'(GLYPH_X + GLYPH_COLS))
		&& (v_addr >= ADDR_W'(GLYPH_Y)) && (v_addr < ADDR_W'(GLYPH_Y + GLYPH_ROWS));
	assign known_key = (key_code == SC_Q) || (key_code == SC_D);
	assign row_bits = glyph_row(key_code, v_rel[ROW_W-1:0]);
	assign pixel_on = active && key_held && known_key && in_box && row_bits[h_rel[COL_W-1:0]];

	// one cycle behind the address, syncs are delayed to match
	always_ff @(posedge clk) begin
		if (rst)
			pixel <= 1'b0;
		else
			pixel <= pixel_on;
	end

	assign vga_r = {8{pixel}};
	assign vga_g = {8{pixel}};
	assign vga_b = {8{pixel}};

endmodule

//--- kbd_pkg.sv
package kbd_pkg;

	// ps/2 scan code set 2
	localparam int unsigned SC_W = 8;
	localparam logic [SC_W-1:0] SC_BREAK = 8'hF0;
	localparam logic [SC_W-1:0] SC_Q = 8'h15;
	localparam logic [SC_W-1:0] SC_D = 8'h23;

	// glyph cell size
	localparam int unsigned GLYPH_ROWS = 16;
	localparam int unsigned GLYPH_COLS = 9;

	// 640x480 at 60 Hz, horizontal in pixel clocks
	localparam int unsigned H_VISIBLE = 640;
	localparam int unsigned H_FRONT = 16;
	localparam int unsigned H_SYNC = 96;
	localparam int unsigned H_BACK = 48;
	localparam int unsigned H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

	// vertical in lines
	localparam int unsigned V_VISIBLE = 480;
	localparam int unsigned V_FRONT = 10;
	localparam int unsigned V_SYNC = 2;
	localparam int unsigned V_BACK = 33;
	localparam int unsigned V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

	// pixel address width, covers H_TOTAL and V_TOTAL
	localparam int unsigned ADDR_W = 10;

endpackage

//--- kbd_vga_tb.sv
module kbd_vga_tb;
	import kbd_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int GLYPH_X = 312;
	localparam int GLYPH_Y = 232;
	localparam bit [8:0] Q_ROW = 9'h0fc;
	// four frames, plus sixteen ps/2 frames of 208 clocks
	localparam int TIMEOUT_CYC = 4 * H_TOTAL * V_TOTAL + 16 * 208;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        ps2_clk = 1'b1;
	logic        ps2_data = 1'b1;
	logic [15:0] ledr;
	logic        vga_clk;
	logic        vga_hsync;
	logic        vga_vsync;
	logic        vga_blank_n;
	logic [7:0]  vga_r;
	logic [7:0]  vga_g;
	logic [7:0]  vga_b;

	// expected decoder state
	bit [7:0]  exp_code;
	bit        exp_held;
	bit [7:0]  exp_count;
	bit        exp_perr;
	bit        exp_ovf;
	bit        in_break;
	int        queued;
	bit [15:0] exp_ledr;
	// key state on screen, taken at vsync
	bit [7:0]  show_code;
	bit        show_held;
	bit        pix_exp;
	// raster measurements
	int        hs_low;
	int        hs_per;
	int        vs_low;
	int        vs_per;
	int        px;
	int        py;
	int        errors;
	int        tests;
	int        seed = 32'h7724_40d6;

	kbd_vga_top #(.FIFO_DEPTH(FIFO_DEPTH), .GLYPH_X(GLYPH_X), .GLYPH_Y(GLYPH_Y)) dut (.*);

	always #20 clk = ~clk;

	assign exp_ledr = {1'b0, exp_count[3:0], exp_perr, exp_ovf, exp_held, exp_code};
	// q glyph is 0fch on rows 6 and 9, bit 0 leftmost
	assign pix_exp = vga_blank_n && show_held && (show_code == SC_Q) && (px >= GLYPH_X)
		&& (px < GLYPH_X + GLYPH_COLS) && (py == GLYPH_Y + 6 || py == GLYPH_Y + 9)
		&& Q_ROW[px - GLYPH_X];

	always @(posedge clk) begin
		if (!rst) begin
			hs_low <= vga_hsync ? 0 : hs_low + 1;
			vs_low <= vga_vsync ? 0 : vs_low + 1;
			// period counters stay at zero until the first pulse
			hs_per <= (!vga_hsync && hs_low == 0) ? 1 : hs_per + int'(hs_per != 0);
			vs_per <= (!vga_vsync && vs_low == 0) ? 1 : vs_per + int'(vs_per != 0);
			px <= vga_blank_n ? px + 1 : 0;
			if (!vga_vsync)
				py <= 0;
			else if (!vga_blank_n && px != 0)
				py <= py + 1;
			if (!vga_vsync) begin
				show_code <= exp_code;
				show_held <= exp_held;
			end
		end
	end

	// vga clock follows the system clock
	always @(clk) begin
		#1;
		a_vga_clk: assert (vga_clk === clk)
			else report_mismatch("vga_clk", vga_clk, clk);
	end

	a_hs_width: assert property (@(posedge clk) disable iff (rst)
		vga_hsync && hs_low != 0 |-> hs_low == H_SYNC)
		else report_mismatch("vga_hsync low width", $sampled(hs_low), H_SYNC);
	a_hs_period: assert property (@(posedge clk) disable iff (rst)
		!vga_hsync && hs_low == 0 && hs_per != 0 |-> hs_per == H_TOTAL)
		else report_mismatch("vga_hsync period", $sampled(hs_per), H_TOTAL);
	a_vs_width: assert property (@(posedge clk) disable iff (rst)
		vga_vsync && vs_low != 0 |-> vs_low == V_SYNC * H_TOTAL)
		else report_mismatch("vga_vsync low width", $sampled(vs_low), V_SYNC * H_TOTAL);
	a_vs_period: assert property (@(posedge clk) disable iff (rst)
		!vga_vsync && vs_low == 0 && vs_per != 0 |-> vs_per == V_TOTAL * H_TOTAL)
		else report_mismatch("vga_vsync period", $sampled(vs_per), V_TOTAL * H_TOTAL);
	a_blank_width: assert property (@(posedge clk) disable iff (rst)
		!vga_blank_n && px != 0 |-> px == H_VISIBLE)
		else report_mismatch("vga_blank_n high width", $sampled(px), H_VISIBLE);
	a_frame_lines: assert property (@(posedge clk) disable iff (rst)
		!vga_vsync && vs_low == 0 |-> py == V_VISIBLE)
		else report_mismatch("vga_blank_n lines per frame", $sampled(py), V_VISIBLE);
	a_status_end: assert property (@(posedge clk) disable iff (rst)
		$fell(dut.vblank) |-> ledr == exp_ledr)
		else report_mismatch("ledr", $sampled(ledr), $sampled(exp_ledr));
	a_status_start: assert property (@(posedge clk) disable iff (rst)
		$rose(dut.vblank) |-> {ledr[15], ledr[10:9]} == {queued != 0, exp_perr, exp_ovf})
		else report_mismatch("ledr[15,10:9]", $sampled({ledr[15], ledr[10:9]}),
			$sampled({queued != 0, exp_perr, exp_ovf}));
	// d bitmap is not modelled
	a_pixel: assert property (@(posedge clk) disable iff (rst)
		show_code != SC_D |-> {vga_r, vga_g, vga_b} == {24{pix_exp}})
		else report_mismatch("vga_rgb", $sampled({vga_r, vga_g, vga_b}),
			$sampled({24{pix_exp}}));

	task automatic report_mismatch(input string name, input int got, input int want);
		$display("Mismatch at %0t: %s is 'h%0h, expected 'h%0h", $time, name, got, want);
		errors++;
	endtask

	task automatic test_done(input string name);
		tests++;
		$display("test %0d %s finished at %0t, %0d errors so far", tests, name, $time, errors);
	endtask

	// one ps/2 frame lsb first, 16 clocks per bit, then the expected state follows
	task automatic send_frame(input bit [7:0] code, input bit bad_parity);
		bit [10:0] bits;
		bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_data <= bits[i];
			repeat (4) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (8) @(posedge clk);
			ps2_clk <= 1'b1;
			repeat (3) @(posedge clk);
		end
		repeat (32) @(posedge clk);
		if (bad_parity) begin
			exp_perr = 1'b1;
		end else if (queued == FIFO_DEPTH) begin
			exp_ovf = 1'b1;
		end else begin
			queued++;
			if (in_break) begin
				in_break = 1'b0;
				if (code == exp_code)
					exp_held = 1'b0;
			end else if (code == SC_BREAK) begin
				in_break = 1'b1;
			end else begin
				// repeats of the held key are not new presses
				if (!(exp_held && code == exp_code))
					exp_count++;
				exp_code = code;
				exp_held = 1'b1;
			end
		end
	endtask

	// returns just after vertical blanking ends and its status check has run
	task automatic wait_frame();
		wait (dut.vblank);
		wait (!dut.vblank);
		repeat (2) @(posedge clk);
		queued = 0;
	endtask

	initial begin
		bit [7:0] code;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// frame 0 press q
		send_frame(SC_Q, 1'b0);
		wait_frame();
		// frame 1 shows q, gets a repeat and a corrupt d
		send_frame(SC_Q, 1'b0);
		send_frame(SC_D, 1'b1);
		wait_frame();
		test_done("parity_error");
		send_frame(SC_BREAK, 1'b0);
		send_frame(SC_Q, 1'b0);
		wait_frame();
		test_done("make_break");
		// frame 3 is black, fifo gets overrun
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			code = 8'($random(seed));
			if (code == SC_BREAK)
				code = 8'h1c;
			send_frame(code, 1'b0);
		end
		wait_frame();
		test_done("glyph_pixels");
		test_done("overflow");
		test_done("sync_timing");
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(TIMEOUT_CYC * 40);
		$display("timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYC);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- kbd_vga_top.sv
module kbd_vga_top #(
	parameter int unsigned FIFO_DEPTH = 4,
	parameter int unsigned GLYPH_X = 312,
	parameter int unsigned GLYPH_Y = 232
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        ps2_clk,
	input  logic        ps2_data,
	output logic [15:0] ledr,
	output logic        vga_clk,
	output logic        vga_hsync,
	output logic        vga_vsync,
	output logic        vga_blank_n,
	output logic [7:0]  vga_r,
	output logic [7:0]  vga_g,
	output logic [7:0]  vga_b
);
	import kbd_pkg::*;

	logic [SC_W-1:0]   rx_data;
	logic              rx_valid;
	logic              rx_error;
	logic [SC_W-1:0]   fifo_data;
	logic              ready;
	logic              overflow;
	logic              pop;
	logic [SC_W-1:0]   key_code;
	logic              key_held;
	logic [7:0]        press_count;
	logic              parity_err;
	logic [ADDR_W-1:0] h_addr;
	logic [ADDR_W-1:0] v_addr;
	logic              active;
	logic              vblank;

	// pixel clock is the system clock
	assign vga_clk = clk;

	ps2_rx u_rx (
		.clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_error(rx_error)
	);

	ps2_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid), .pop(pop),
		.data(fifo_data), .ready(ready), .overflow(overflow)
	);

	key_decoder u_dec (
		.clk(clk), .rst(rst), .data(fifo_data), .ready(ready), .vblank(vblank),
		.rx_error(rx_error), .pop(pop), .key_code(key_code), .key_held(key_held),
		.press_count(press_count), .parity_err(parity_err)
	);

	vga_timing u_timing (
		.clk(clk), .rst(rst), .h_addr(h_addr), .v_addr(v_addr), .active(active),
		.vblank(vblank), .hsync(vga_hsync), .vsync(vga_vsync), .blank_n(vga_blank_n)
	);

	char_render #(.GLYPH_X(GLYPH_X), .GLYPH_Y(GLYPH_Y)) u_render (
		.clk(clk), .rst(rst), .h_addr(h_addr), .v_addr(v_addr), .active(active),
		.key_code(key_code), .key_held(key_held),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	// status lamps
	assign ledr = {ready, press_count[3:0], parity_err, overflow, key_held, key_code};

endmodule

//--- key_decoder.sv
module key_decoder (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [kbd_pkg::SC_W-1:0] data,
	input  logic                     ready,
	input  logic                     vblank,
	input  logic                     rx_error,
	output logic                     pop,
	output logic [kbd_pkg::SC_W-1:0] key_code,
	output logic                     key_held,
	output logic [7:0]               press_count,
	output logic                     parity_err
);
	import kbd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BREAK,
		ST_DISCARD
	} state_t;

	state_t state;

	// codes only consumed while the raster is in vertical blanking
	assign pop = vblank && ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			key_code <= '0;
			key_held <= 1'b0;
			press_count <= '0;
			parity_err <= 1'b0;
		end else begin
			if (rx_error)
				parity_err <= 1'b1;
			if (pop) begin
				case (state)
					ST_IDLE: begin
						if (data == SC_BREAK) begin
							state <= ST_BREAK;
						end else begin
							key_code <= data;
							key_held <= 1'b1;
							// typematic repeat of the held key is not a new press
							if (!(key_held && data == key_code))
								press_count <= press_count + 8'd1;
						end
					end
					ST_BREAK: begin
						// doubled prefix, a byte went missing somewhere
						if (data == SC_BREAK) begin
							state <= ST_DISCARD;
						end else begin
							if (data == key_code)
								key_held <= 1'b0;
							state <= ST_IDLE;
						end
					end
					ST_DISCARD: state <= ST_IDLE;
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// key state only moves after a pop taken during blanking
	a_key_frozen_active: assert property (@(posedge clk) disable iff (rst)
		!$past(vblank) |-> $stable(key_code) && $stable(key_held)
			&& $stable(press_count));

endmodule

//--- ps2_fifo.sv
module ps2_fifo #(
	parameter int unsigned FIFO_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [kbd_pkg::SC_W-1:0] rx_data,
	input  logic                     rx_valid,
	input  logic                     pop,
	output logic [kbd_pkg::SC_W-1:0] data,
	output logic                     ready,
	output logic                     overflow
);
	import kbd_pkg::*;

	localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

	logic [SC_W-1:0]  mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             push;

	assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
	// a pop in the same cycle frees the slot
	assign push = rx_valid && (!full || pop);
	assign ready = (count != '0);
	assign data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// sticky until reset
			if (rx_valid && full && !pop)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= rx_data;
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> ready);

endmodule

//--- ps2_rx.sv
module ps2_rx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ps2_clk,
	input  logic                     ps2_data,
	output logic [kbd_pkg::SC_W-1:0] rx_data,
	output logic                     rx_valid,
	output logic                     rx_error
);
	import kbd_pkg::*;

	localparam int unsigned FRAME_BITS = 11;
	localparam int unsigned TIMEOUT = 2048;

	logic [1:0]                 clk_sync;
	logic [1:0]                 data_sync;
	logic                       clk_prev;
	logic                       fall;
	logic [3:0]                 bit_cnt;
	logic [FRAME_BITS-1:0]      shift;
	logic [FRAME_BITS-1:0]      frame;
	logic [$clog2(TIMEOUT)-1:0] idle_cnt;
	logic                       last_bit;
	logic                       frame_ok;

	assign fall = clk_prev && !clk_sync[1];
	// bits arrive lsb first, so shift in from the top
	assign frame = {data_sync[1], shift[FRAME_BITS-1:1]};
	assign last_bit = fall && (bit_cnt == 4'(FRAME_BITS - 1));
	// start 0, stop 1, odd parity over data and parity bit
	assign frame_ok = !frame[0] && frame[FRAME_BITS-1] && (^frame[SC_W+1:1]);

	always_ff @(posedge clk) begin
		if (rst) begin
			clk_sync <= 2'b11;
			clk_prev <= 1'b1;
			bit_cnt <= '0;
			idle_cnt <= '0;
			rx_valid <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			clk_prev <= clk_sync[1];
			rx_valid <= last_bit && frame_ok;
			rx_error <= last_bit && !frame_ok;
			if (fall) begin
				idle_cnt <= '0;
				bit_cnt <= last_bit ? 4'd0 : bit_cnt + 4'd1;
			end else if (bit_cnt != 4'd0) begin
				// keyboard went quiet mid-frame, start over
				if (&idle_cnt) begin
					bit_cnt <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		data_sync <= {data_sync[0], ps2_data};
		if (fall)
			shift <= frame;
		if (last_bit)
			rx_data <= frame[SC_W:1];
	end

	a_valid_error_excl: assert property (@(posedge clk) disable iff (rst)
		!(rx_valid && rx_error));

endmodule

//--- src.f
kbd_pkg.sv
ps2_rx.sv
ps2_fifo.sv
key_decoder.sv
char_render.sv
vga_timing.sv
kbd_vga_top.sv
kbd_vga_tb.sv

//--- vga_timing.sv
module vga_timing (
	input  logic                       clk,
	input  logic                       rst,
	output logic [kbd_pkg::ADDR_W-1:0] h_addr,
	output logic [kbd_pkg::ADDR_W-1:0] v_addr,
	output logic                       active,
	output logic                       vblank,
	output logic                       hsync,
	output logic                       vsync,
	output logic                       blank_n
);
	import kbd_pkg::*;

	logic [ADDR_W-1:0] h_next;
	logic [ADDR_W-1:0] v_next;

	always_comb begin
		h_next = h_addr + ADDR_W'(1);
		v_next = v_addr;
		if (h_addr == ADDR_W'(H_TOTAL - 1)) begin
			h_next = '0;
			v_next = (v_addr == ADDR_W'(V_TOTAL - 1)) ? '0 : v_addr + ADDR_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			h_addr <= '0;
			v_addr <= '0;
			// counters at 0,0 are inside the visible area
			active <= 1'b1;
			vblank <= 1'b0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			h_addr <= h_next;
			v_addr <= v_next;
			active <= (h_next < ADDR_W'(H_VISIBLE)) && (v_next < ADDR_W'(V_VISIBLE));
			vblank <= (v_next >= ADDR_W'(V_VISIBLE));
			// delayed by one to line up with the renderer
			hsync <= !((h_addr >= ADDR_W'(H_VISIBLE + H_FRONT))
				&& (h_addr < ADDR_W'(H_VISIBLE + H_FRONT + H_SYNC)));
			vsync <= !((v_addr >= ADDR_W'(V_VISIBLE + V_FRONT))
				&& (v_addr < ADDR_W'(V_VISIBLE + V_FRONT + V_SYNC)));
			blank_n <= active;
		end
	end

	a_h_in_range: assert property (@(posedge clk) disable iff (rst)
		h_addr < ADDR_W'(H_TOTAL));

endmodule
